/* Bender.yml */
package:
  name: piano

sources:
  - common/pianoPkg.sv
  - hw/ps2Receiver.sv
  - hw/keyTracker.sv
  - hw/notePriority.sv
  - synth/toneSynth.sv
  - synth/pwmModulator.sv
  - hw/pianoTop.sv
  - target: simulation
    files:
      - verif/clockGen.sv
      - verif/pianoTb.sv

/* common/pianoPkg.sv */
package pianoPkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////

	// Two octaves of keys at most
	localparam int keyMax = 24;

	// Audio sample width, also the PWM frame counter width
	localparam int sampleBits = 8;

	// Sine table length, one full period
	localparam int tableSize = 32;

	// Key index, 0 is the lowest C
	typedef logic [4:0] noteT;

	// Unsigned audio sample
	typedef logic [sampleBits-1:0] sampleT;

	// Result of a scan-code lookup
	typedef struct packed {
		logic valid;
		noteT key;
	} keyMapT;

	////////////////////////////////////////
	// PS/2 set 2 prefixes
	////////////////////////////////////////

	localparam logic [7:0] breakCode = 8'hF0;
	localparam logic [7:0] extendCode = 8'hE0;

	// Lower octave on Z..M, upper octave on Q..U
	// Black keys on the row above each white row
	function automatic keyMapT keyOfScan(input logic [7:0] code);
		keyMapT m;
		m.valid = 1'b1;
		case (code)
			8'h1A: m.key = 5'd0;
			8'h1B: m.key = 5'd1;
			8'h22: m.key = 5'd2;
			8'h23: m.key = 5'd3;
			8'h21: m.key = 5'd4;
			8'h2A: m.key = 5'd5;
			8'h34: m.key = 5'd6;
			8'h32: m.key = 5'd7;
			8'h33: m.key = 5'd8;
			8'h31: m.key = 5'd9;
			8'h3B: m.key = 5'd10;
			8'h3A: m.key = 5'd11;
			8'h15: m.key = 5'd12;
			8'h1E: m.key = 5'd13;
			8'h1D: m.key = 5'd14;
			8'h26: m.key = 5'd15;
			8'h24: m.key = 5'd16;
			8'h2D: m.key = 5'd17;
			8'h2E: m.key = 5'd18;
			8'h2C: m.key = 5'd19;
			8'h36: m.key = 5'd20;
			8'h35: m.key = 5'd21;
			8'h3D: m.key = 5'd22;
			8'h3C: m.key = 5'd23;
			default:
			begin
				m.valid = 1'b0;
				m.key = 5'd0;
			end
		endcase
		return m;
	endfunction

	// PWM frames per table step, higher notes step faster
	function automatic logic [4:0] stepFrames(input noteT n);
		return 5'd25 - n;
	endfunction

endpackage

/* filelist.f */
common/pianoPkg.sv
hw/ps2Receiver.sv
hw/keyTracker.sv
hw/notePriority.sv
synth/toneSynth.sv
synth/pwmModulator.sv
hw/pianoTop.sv
verif/clockGen.sv
verif/pianoTb.sv

/* hw/keyTracker.sv */
`timescale 1ns/1ps

module keyTracker #(
	parameter int octaves = 2
) (
	input logic mclk,
	input logic arstN,
	input logic byteValid,
	input pianoPkg::sampleT byteData,
	output logic [pianoPkg::keyMax-1:0] keys
);

	import pianoPkg::*;

	keyMapT map;
	logic inRange;
	logic breakPend;
	logic extPend;

	////////////////////////////////////////
	// Scan-code lookup
	////////////////////////////////////////

	assign map = keyOfScan(byteData);

	// Keys past the configured octaves are ignored
	assign inRange = map.valid && (int'(map.key) < 12 * octaves);

	////////////////////////////////////////
	// Prefix tracking and bitmap
	////////////////////////////////////////

	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			keys <= '0;
			breakPend <= 1'b0;
			extPend <= 1'b0;
		end
		else if (byteValid)
		begin
			if (byteData == breakCode)
			begin
				// Release follows
				breakPend <= 1'b1;
			end
			else if (byteData == extendCode)
			begin
				// Extended key follows, E0 F0 xx keeps both flags
				extPend <= 1'b1;
			end
			else
			begin
				// Extended keys share codes with piano keys
				if (inRange && !extPend)
					keys[map.key] <= ~breakPend;
				// Prefixes apply to one code only
				breakPend <= 1'b0;
				extPend <= 1'b0;
			end
		end
	end

endmodule

/* hw/notePriority.sv */
`timescale 1ns/1ps

module notePriority #(
	parameter int octaves = 2
) (
	input logic mclk,
	input logic arstN,
	input logic [pianoPkg::keyMax-1:0] keys,
	output pianoPkg::noteT note,
	output logic press
);

	import pianoPkg::*;

	localparam int keyCount = 12 * octaves;

	logic [keyMax-1:0] prevKeys;
	logic [keyMax-1:0] newKeys;

	// Highest set bit within the octave range
	function automatic noteT highestKey(input logic [keyMax-1:0] v);
		noteT idx;
		idx = '0;
		for (int i = 0; i < keyCount; i++)
		begin
			if (v[i])
				idx = noteT'(i);
		end
		return idx;
	endfunction

	// Keys that went down this cycle
	assign newKeys = keys & ~prevKeys;

	////////////////////////////////////////
	// Last-pressed selection
	////////////////////////////////////////

	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			prevKeys <= '0;
			note <= '0;
			press <= 1'b0;
		end
		else
		begin
			prevKeys <= keys;
			press <= |keys;
			// New press wins, highest one on a tie
			if (|newKeys)
				note <= highestKey(newKeys);
			// Sounding key let go, fall back to highest held
			else if (|keys && !keys[note])
				note <= highestKey(keys);
			// Nothing held, note keeps its value
		end
	end

endmodule

/* hw/pianoTop.sv */
`timescale 1ns/1ps

module pianoTop #(
	parameter int octaves = 2,
	parameter int syncStages = 2
) (
	input logic mclk,
	input logic arstN,
	input logic ps2Clk,
	input logic ps2Data,
	output logic [7:0] led,
	output logic pwmOut
);

	import pianoPkg::*;

	logic byteValid;
	sampleT byteData;
	logic [keyMax-1:0] keys;
	noteT note;
	logic press;
	logic frameStart;
	sampleT sample;
	logic sampleOn;

	////////////////////////////////////////
	// Keyboard side
	////////////////////////////////////////

	ps2Receiver #(
		.syncStages(syncStages)
	) u_ps2Receiver (
		.mclk(mclk),
		.arstN(arstN),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.byteValid(byteValid),
		.byteData(byteData)
	);

	keyTracker #(
		.octaves(octaves)
	) u_keyTracker (
		.mclk(mclk),
		.arstN(arstN),
		.byteValid(byteValid),
		.byteData(byteData),
		.keys(keys)
	);

	notePriority #(
		.octaves(octaves)
	) u_notePriority (
		.mclk(mclk),
		.arstN(arstN),
		.keys(keys),
		.note(note),
		.press(press)
	);

	////////////////////////////////////////
	// Audio side
	////////////////////////////////////////

	toneSynth u_toneSynth (
		.mclk(mclk),
		.arstN(arstN),
		.frameStart(frameStart),
		.note(note),
		.press(press),
		.sample(sample),
		.sampleOn(sampleOn)
	);

	pwmModulator u_pwmModulator (
		.mclk(mclk),
		.arstN(arstN),
		.sample(sample),
		.sampleOn(sampleOn),
		.frameStart(frameStart),
		.pwmOut(pwmOut)
	);

	// Press on bit 7, note on the low five
	assign led = {press, 2'b00, note};

endmodule

/* hw/ps2Receiver.sv */
`timescale 1ns/1ps

module ps2Receiver #(
	parameter int syncStages = 2
) (
	input logic mclk,
	input logic arstN,
	input logic ps2Clk,
	input logic ps2Data,
	output logic byteValid,
	output pianoPkg::sampleT byteData
);

	// Idle cycles before a partial frame is dropped
	localparam int watchdogBits = 12;

	logic [syncStages-1:0] clkSync;
	logic [syncStages-1:0] dataSync;
	logic clkPrev;
	logic clkFall;
	logic clkRise;
	logic [10:0] frame;
	logic [3:0] bitCnt;
	logic [watchdogBits-1:0] idleCnt;
	logic frameGood;

	////////////////////////////////////////
	// Line synchronisers
	////////////////////////////////////////

	// Both lines idle high, so reset to ones
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			clkSync <= '1;
			dataSync <= '1;
			clkPrev <= 1'b1;
		end
		else
		begin
			clkSync <= {clkSync[syncStages-2:0], ps2Clk};
			dataSync <= {dataSync[syncStages-2:0], ps2Data};
			clkPrev <= clkSync[syncStages-1];
		end
	end

	assign clkFall = clkPrev & ~clkSync[syncStages-1];
	assign clkRise = ~clkPrev & clkSync[syncStages-1];

	// Start low, stop high, odd parity over data and parity bit
	assign frameGood = ~frame[0] & frame[10] & (^frame[9:1]);

	////////////////////////////////////////
	// Frame capture
	////////////////////////////////////////

	// LSB first, so shift right and enter at the top
	always_ff @(posedge mclk)
	begin
		if (clkFall && bitCnt != 4'd11)
			frame <= {dataSync[syncStages-1], frame[10:1]};
		if (bitCnt == 4'd11 && clkRise)
			byteData <= frame[8:1];
	end

	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			bitCnt <= 4'd0;
			idleCnt <= '0;
			byteValid <= 1'b0;
		end
		else
		begin
			byteValid <= 1'b0;
			// Stop bit done, close on the next rising edge
			if (bitCnt == 4'd11 && clkRise)
			begin
				byteValid <= frameGood;
				bitCnt <= 4'd0;
				idleCnt <= '0;
			end
			else if (clkFall && bitCnt != 4'd11)
			begin
				bitCnt <= bitCnt + 4'd1;
				idleCnt <= '0;
			end
			else if (bitCnt != 4'd0)
			begin
				// Watchdog on a stalled frame
				if (&idleCnt)
				begin
					bitCnt <= 4'd0;
					idleCnt <= '0;
				end
				else
					idleCnt <= idleCnt + 1'b1;
			end
		end
	end

endmodule

/* synth/pwmModulator.sv */
`timescale 1ns/1ps

module pwmModulator (
	input logic mclk,
	input logic arstN,
	input pianoPkg::sampleT sample,
	input logic sampleOn,
	output logic frameStart,
	output logic pwmOut
);

	import pianoPkg::*;

	logic [sampleBits-1:0] cnt;
	sampleT sampleQ;
	logic onQ;

	// First cycle of each 256-cycle frame
	assign frameStart = (cnt == '0);

	always_ff @(posedge mclk)
	begin
		if (frameStart)
			sampleQ <= sample;
	end

	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			cnt <= '0;
			onQ <= 1'b0;
			pwmOut <= 1'b0;
		end
		else
		begin
			cnt <= cnt + 1'b1;
			if (frameStart)
			begin
				onQ <= sampleOn;
				// Latch not yet loaded, compare the incoming sample
				pwmOut <= sampleOn && (sample != '0);
			end
			else
				pwmOut <= onQ && (cnt < sampleQ);
		end
	end

endmodule

/* synth/toneSynth.sv */
`timescale 1ns/1ps

module toneSynth (
	input logic mclk,
	input logic arstN,
	input logic frameStart,
	input pianoPkg::noteT note,
	input logic press,
	output pianoPkg::sampleT sample,
	output logic sampleOn
);

	import pianoPkg::*;

	localparam int idxBits = $clog2(tableSize);

	// 128 + 127 * sin(2*pi*k/32), rounded
	localparam sampleT sineTable [tableSize] = '{
		8'd128, 8'd153, 8'd177, 8'd199, 8'd218, 8'd234, 8'd245, 8'd253,
		8'd255, 8'd253, 8'd245, 8'd234, 8'd218, 8'd199, 8'd177, 8'd153,
		8'd128, 8'd103, 8'd79,  8'd57,  8'd38,  8'd22,  8'd11,  8'd3,
		8'd1,   8'd3,   8'd11,  8'd22,  8'd38,  8'd57,  8'd79,  8'd103
	};

	logic [idxBits-1:0] idx;
	logic [4:0] frameCnt;
	logic pressQ;
	noteT noteQ;
	logic restartNow;
	logic restartPend;

	// Fresh press or a new note while held
	assign restartNow = press && (!pressQ || note != noteQ);

	assign sample = sineTable[idx];

	////////////////////////////////////////
	// Phase stepper
	////////////////////////////////////////

	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			idx <= '0;
			frameCnt <= 5'd0;
			pressQ <= 1'b0;
			noteQ <= '0;
			restartPend <= 1'b0;
			sampleOn <= 1'b0;
		end
		else
		begin
			pressQ <= press;
			noteQ <= note;
			if (frameStart)
			begin
				sampleOn <= press;
				restartPend <= 1'b0;
				// Every note starts at phase zero
				if (restartPend || restartNow)
				begin
					idx <= '0;
					frameCnt <= 5'd0;
				end
				else if (press)
				begin
					if (frameCnt == stepFrames(note) - 5'd1)
					begin
						frameCnt <= 5'd0;
						// Wraps at the table end
						idx <= idx + 1'b1;
					end
					else
						frameCnt <= frameCnt + 5'd1;
				end
			end
			else if (restartNow)
				restartPend <= 1'b1;
		end
	end

endmodule

/* verif/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
	parameter real period = 4.0,
	parameter int resetCycles = 5
) (
	output logic mclk,
	output logic arstN
);

	// Free-running clock
	initial
	begin
		mclk = 1'b0;
		forever
			#(period / 2.0) mclk = ~mclk;
	end

	// Reset held low, released on a rising edge
	initial
	begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge mclk);
		arstN <= 1'b1;
	end

endmodule

/* verif/pianoTb.sv */
`timescale 1ns/1ps

module pianoTb;

	import pianoPkg::*;

	// Half of the 40-cycle PS/2 bit period
	localparam int halfBit = 20;
	localparam int strobeWait = 40;
	localparam real piVal = 3.14159265358979;
	localparam logic [7:0] releasePrefix = 8'hF0;
	localparam logic [7:0] extPrefix = 8'hE0;
	// The A key, not part of the piano layout
	localparam logic [7:0] unmappedCode = 8'h1C;

	// Set 2 make codes, Z S X D C V G B H N J M then Q 2 W 3 E R 5 T 6 Y 7 U
	localparam logic [7:0] scanTable [24] = '{
		8'h1A, 8'h1B, 8'h22, 8'h23, 8'h21, 8'h2A, 8'h34, 8'h32,
		8'h33, 8'h31, 8'h3B, 8'h3A, 8'h15, 8'h1E, 8'h1D, 8'h26,
		8'h24, 8'h2D, 8'h2E, 8'h2C, 8'h36, 8'h35, 8'h3D, 8'h3C
	};

	logic mclk;
	logic arstN;
	logic ps2Clk;
	logic ps2Data;
	logic [7:0] led;
	logic pwmOut;

	logic [keyMax-1:0] held;
	noteT expNote;
	logic expPress;
	logic [15:0] lfsr;
	int valueErrors = 0;
	int otherErrors = 0;
	event ledCheck;

	clockGen #(
		.period(4.0),
		.resetCycles(5)
	) u_clockGen (
		.mclk(mclk),
		.arstN(arstN)
	);

	pianoTop #(
		.octaves(2),
		.syncStages(2)
	) u_dut (
		.mclk(mclk),
		.arstN(arstN),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.led(led),
		.pwmOut(pwmOut)
	);

	////////////////////////////////////////
	// Expected values
	////////////////////////////////////////

	function automatic logic [7:0] scanOf(input int k);
		return scanTable[k];
	endfunction

	function automatic noteT topKey(input logic [keyMax-1:0] v);
		noteT idx;
		idx = '0;
		for (int i = 0; i < keyMax; i++)
		begin
			if (v[i])
				idx = noteT'(i);
		end
		return idx;
	endfunction

	// Last pressed wins, highest held once the sounding key is let go
	function automatic noteT nextNote(input logic [keyMax-1:0] prior,
		input logic [keyMax-1:0] after, input noteT cur);
		logic [keyMax-1:0] fresh;
		noteT result;
		fresh = after & ~prior;
		result = cur;
		if (fresh != '0)
			result = topKey(fresh);
		else if (after != '0 && !after[cur])
			result = topKey(after);
		return result;
	endfunction

	function automatic int stepRef(input noteT n);
		return 25 - int'(n);
	endfunction

	function automatic sampleT sineRef(input int k);
		real v;
		v = 128.0 + 127.0 * $sin(2.0 * piVal * k / tableSize);
		return sampleT'($rtoi(v + 0.5));
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randBits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsrNext(lfsr);
		end
	endtask

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic checkNote(input string name, input noteT got, input noteT exp);
		if (got !== exp)
		begin
			$display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
			valueErrors++;
		end
	endtask

	task automatic checkPress(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
			valueErrors++;
		end
	endtask

	task automatic checkWidth(input string name, input sampleT got, input sampleT exp);
		if (got !== exp)
		begin
			$display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
			valueErrors++;
		end
	endtask

	// Display against the model whenever stimulus asks
	always @(ledCheck)
	begin
		checkNote("led[4:0]", led[4:0], expNote);
		checkPress("led[7]", led[7], expPress);
		checkPress("led[6]", led[6], 1'b0);
		checkPress("led[5]", led[5], 1'b0);
	end

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	// Start, 8 data bits LSB first, odd parity, stop
	task automatic sendByte(input logic [7:0] code, input logic badParity);
		logic [10:0] bits;
		logic seen;
		int n;
		bits = {1'b1, (~^code) ^ badParity, code, 1'b0};
		for (int i = 0; i < 11; i++)
		begin
			@(posedge mclk);
			ps2Data <= bits[i];
			repeat (halfBit) @(posedge mclk);
			ps2Clk <= 1'b0;
			repeat (halfBit) @(posedge mclk);
			ps2Clk <= 1'b1;
		end
		seen = 1'b0;
		for (n = 0; n < strobeWait && !seen; n++)
		begin
			@(negedge mclk);
			seen = u_dut.byteValid;
		end
		if (badParity && seen)
		begin
			$display("A frame with bad parity produced a byte strobe at %0d ns", $time);
			otherErrors++;
		end
		else if (!badParity && !seen)
		begin
			$display("Timed out waiting for the byte strobe at %0d ns", $time);
			otherErrors++;
		end
		// Keys one cycle later, note one more
		repeat (2) @(posedge mclk);
		@(negedge mclk);
	endtask

	task automatic keyEvent(input int k, input logic down);
		logic [keyMax-1:0] prior;
		prior = held;
		if (!down)
			sendByte(releasePrefix, 1'b0);
		sendByte(scanOf(k), 1'b0);
		held[k] = down;
		expNote = nextNote(prior, held, expNote);
		expPress = |held;
		-> ledCheck;
	endtask

	// Width of the next whole high pulse
	task automatic measurePulse(output sampleT width, output logic ok);
		int n;
		ok = 1'b0;
		width = '0;
		n = 0;
		// Let a pulse in progress finish first
		while (pwmOut !== 1'b0 && n < 300)
		begin
			@(negedge mclk);
			n++;
		end
		n = 0;
		do
		begin
			@(negedge mclk);
			n++;
		end
		while (pwmOut !== 1'b1 && n < 1200);
		if (pwmOut !== 1'b1)
		begin
			$display("Timed out waiting for a pwmOut pulse at %0d ns", $time);
			otherErrors++;
			return;
		end
		n = 0;
		while (pwmOut === 1'b1 && n < 300)
		begin
			n++;
			@(negedge mclk);
		end
		if (n >= 300)
		begin
			$display("pwmOut stuck high at %0d ns", $time);
			otherErrors++;
			return;
		end
		width = sampleT'(n);
		ok = 1'b1;
	endtask

	// No pulse at all in the window, so no rising edge
	task automatic expectSilence(input int settle, input int window);
		logic flagged;
		flagged = 1'b0;
		repeat (settle) @(negedge mclk);
		for (int n = 0; n < window; n++)
		begin
			@(negedge mclk);
			if (pwmOut !== 1'b0 && !flagged)
			begin
				$display("pwmOut pulsed while no key was held at %0d ns", $time);
				otherErrors++;
				flagged = 1'b1;
			end
		end
	endtask

	task automatic checkTone(input int k);
		sampleT w0;
		sampleT w;
		logic ok;
		int idx;
		int run;
		int step;
		int tries;
		keyEvent(k, 1'b1);
		step = stepRef(noteT'(k));
		measurePulse(w0, ok);
		// A new note starts from table entry 0
		if (ok)
			checkWidth("pwmOut width", w0, sineRef(0));
		w = w0;
		tries = 0;
		// Skip to the first step boundary
		while (ok && w == w0 && tries < 64)
		begin
			measurePulse(w, ok);
			tries++;
		end
		idx = -1;
		if (ok && w == w0)
		begin
			$display("Pulse width never changed for key %0d", k);
			otherErrors++;
		end
		else if (ok)
		begin
			idx = 1;
			checkWidth("pwmOut width", w, sineRef(idx));
		end
		run = 1;
		for (int p = 0; p < 48 && ok && idx >= 0; p++)
		begin
			measurePulse(w, ok);
			if (ok)
			begin
				if (run == step)
				begin
					idx = (idx + 1) % tableSize;
					run = 0;
				end
				run++;
				checkWidth("pwmOut width", w, sineRef(idx));
			end
		end
		keyEvent(k, 1'b0);
		expectSilence(600, 1000);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		int n;
		int r;
		int k;
		ps2Clk = 1'b1;
		ps2Data = 1'b1;
		held = '0;
		expNote = '0;
		expPress = 1'b0;
		lfsr = 16'd74;

		n = 0;
		while (arstN !== 1'b1 && n < 50)
		begin
			@(negedge mclk);
			n++;
		end
		if (arstN !== 1'b1)
		begin
			$display("Reset was never released");
			otherErrors++;
		end
		-> ledCheck;
		expectSilence(0, 600);

		// Each key alone
		for (k = 0; k < keyMax; k++)
		begin
			keyEvent(k, 1'b1);
			keyEvent(k, 1'b0);
		end

		// Random chords, toggling one key per event
		for (n = 0; n < 48; n++)
		begin
			randBits(5, r);
			k = r % keyMax;
			keyEvent(k, !held[k]);
			randBits(3, r);
			repeat (r * 16) @(posedge mclk);
		end
		for (k = 0; k < keyMax; k++)
		begin
			if (held[k])
				keyEvent(k, 1'b0);
		end
		expectSilence(600, 1000);

		// Bytes that must not disturb the held keys
		keyEvent(5, 1'b1);
		keyEvent(9, 1'b1);
		sendByte(scanOf(14), 1'b1);
		-> ledCheck;
		sendByte(extPrefix, 1'b0);
		sendByte(scanOf(3), 1'b0);
		-> ledCheck;
		sendByte(extPrefix, 1'b0);
		sendByte(releasePrefix, 1'b0);
		sendByte(scanOf(5), 1'b0);
		-> ledCheck;
		sendByte(unmappedCode, 1'b0);
		-> ledCheck;
		keyEvent(17, 1'b0);
		// Falls back to key 5
		keyEvent(9, 1'b0);
		keyEvent(5, 1'b0);
		expectSilence(600, 1000);

		checkTone(23);
		checkTone(20);

		$display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
